//--- spi_host_params.svh
/* SPI host build parameters
   Frame shape, serial clock divider, queue size and trigger monitor constants */
`ifndef SPI_HOST_PARAMS_SVH
`define SPI_HOST_PARAMS_SVH

// Bits per frame, shifted MSB first
`define SPI_DATA_WIDTH 8

// System clocks per sclk half-period
`define SPI_CLK_DIV 4

// Input queue entries, also the producer's starting credits
`define SPI_QUEUE_DEPTH 4

`define SPI_LFSR_SEED 24'hACE123 // Pattern LFSR reset value

// Low byte of the LFSR after its first step from the seed
`define SPI_TRIG_VALUE 8'h46

`endif

//--- spi_host_pkg.sv
/* SPI host shared types
   Engine state encoding and the frame data word */
package spi_host_pkg;

    `include "spi_host_params.svh"

    // One frame worth of serial data
    typedef logic [`SPI_DATA_WIDTH-1:0] spi_frame_t;

    // Shift engine states
    typedef enum logic [1:0] {
        st_idle       = 2'd0, // Waiting for a command
        st_cs_assert  = 2'd1, // Chip select low, MSB on mosi
        st_transfer   = 2'd2,
        st_cs_release = 2'd3  // Chip select high, frame result out
    } spi_state_e;

endpackage

//--- spi_cmd_if.sv
/* Command link between input queue and shift engine
   Queue offers bytes, engine hands back its single credit */
`timescale 1ns/1ps

interface spi_cmd_if import spi_host_pkg::*; ();

    logic       cmd_valid;
    spi_frame_t cmd_data;
    logic       cmd_credit;  // Engine free again
    logic       frame_abort; // Frame ended by the trigger monitor

    modport queue_mp (
        output cmd_valid,
        output cmd_data,
        input  cmd_credit,
        input  frame_abort
    );

    modport engine_mp (
        input  cmd_valid,
        input  cmd_data,
        output cmd_credit,
        output frame_abort
    );

endinterface

//--- spi_cmd_queue.sv
/* Input queue for transmit bytes
   Circular FIFO with producer credits and one downstream engine credit */
`timescale 1ns/1ps
`include "spi_host_params.svh"

module spi_cmd_queue import spi_host_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         in_valid,
    input  spi_frame_t   in_data,
    output logic         in_credit,
    spi_cmd_if.queue_mp  cmd
);

    localparam int DEPTH = `SPI_QUEUE_DEPTH;
    localparam int AW    = $clog2(DEPTH);

    spi_frame_t      mem [DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            eng_credit; // Engine can take a frame
    logic            pop;

    assign pop = eng_credit && (count != '0);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            mem[wr_ptr] <= in_data;
        end
        if (pop) begin
            cmd.cmd_data <= mem[rd_ptr];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            eng_credit    <= 1'b1; // Engine starts empty
            cmd.cmd_valid <= 1'b0;
            in_credit     <= 1'b0;
        end else begin
            cmd.cmd_valid <= pop;
            in_credit     <= pop; // Freed slot goes back to the producer
            if (in_valid) begin
                wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (in_valid && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !in_valid) begin
                count <= count - 1'b1;
            end
            if (cmd.cmd_credit) begin
                eng_credit <= 1'b1;
            end else if (pop) begin
                eng_credit <= 1'b0;
            end
        end
    end

    // Producer must respect its credits
    assert property (@(posedge clk) disable iff (rst)
        !(in_valid && count == (AW + 1)'(DEPTH)));

    // Engine returns a credit only for a frame it was given
    assert property (@(posedge clk) disable iff (rst)
        cmd.cmd_credit |-> !eng_credit);

endmodule

//--- spi_shift_engine.sv
/* SPI mode 0 shift engine
   Runs one MSB-first frame per command with a divided sclk, abortable mid-frame */
`timescale 1ns/1ps
`include "spi_host_params.svh"

module spi_shift_engine import spi_host_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    spi_cmd_if.engine_mp  cmd,
    input  logic          force_abort,
    input  logic          miso,
    output logic          sclk,
    output logic          mosi,
    output logic          cs_n,
    output logic          rx_strobe,
    output spi_frame_t    rx_byte,
    output logic          abort_strobe,
    output logic          frame_end
);

    localparam int W   = `SPI_DATA_WIDTH;
    localparam int DIV = `SPI_CLK_DIV;
    localparam int DW  = $clog2(DIV);
    localparam int BW  = $clog2(W);

    spi_state_e    state;
    logic [DW-1:0] div_cnt;
    logic [BW-1:0] bit_cnt;
    spi_frame_t    tx_shift;
    spi_frame_t    rx_shift;
    logic          half_done;
    logic          sclk_rise;
    logic          sclk_fall;
    logic          abort_hit;

    assign half_done = (state == st_transfer) && (div_cnt == DW'(DIV - 1));
    assign sclk_rise = half_done && !sclk;
    assign sclk_fall = half_done && sclk;

    // A command arriving together with the abort is dropped too
    assign abort_hit = force_abort && ((state != st_idle) || cmd.cmd_valid);

    // Either way the frame is over
    assign frame_end       = rx_strobe | abort_strobe;
    assign cmd.cmd_credit  = rx_strobe | abort_strobe;
    assign cmd.frame_abort = abort_strobe;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state        <= st_idle;
            cs_n         <= 1'b1;
            sclk         <= 1'b0;
            mosi         <= 1'b0;
            div_cnt      <= '0;
            bit_cnt      <= '0;
            rx_strobe    <= 1'b0;
            abort_strobe <= 1'b0;
        end else begin
            rx_strobe    <= 1'b0;
            abort_strobe <= 1'b0;
            if (abort_hit) begin
                state        <= st_idle;
                cs_n         <= 1'b1;
                sclk         <= 1'b0;
                mosi         <= 1'b0;
                div_cnt      <= '0;
                bit_cnt      <= '0;
                abort_strobe <= 1'b1;
            end else begin
                case (state)
                    st_idle: begin
                        if (cmd.cmd_valid) begin
                            state <= st_cs_assert;
                            cs_n  <= 1'b0;
                            mosi  <= cmd.cmd_data[W-1]; // MSB ahead of first rise
                        end
                    end
                    st_cs_assert: begin
                        state   <= st_transfer;
                        div_cnt <= '0;
                    end
                    st_transfer: begin
                        if (half_done) begin
                            div_cnt <= '0;
                            sclk    <= ~sclk;
                            if (sclk_fall) begin
                                if (bit_cnt == BW'(W - 1)) begin
                                    state   <= st_cs_release;
                                    cs_n    <= 1'b1;
                                    mosi    <= 1'b0;
                                    bit_cnt <= '0;
                                end else begin
                                    bit_cnt <= bit_cnt + 1'b1;
                                    mosi    <= tx_shift[W-2];
                                end
                            end
                        end else begin
                            div_cnt <= div_cnt + 1'b1;
                        end
                    end
                    st_cs_release: begin
                        state     <= st_idle;
                        rx_strobe <= 1'b1;
                    end
                    default: state <= st_idle;
                endcase
            end
        end
    end

    // Shift registers and result byte
    always_ff @(posedge clk) begin
        if (state == st_idle && cmd.cmd_valid) begin
            tx_shift <= cmd.cmd_data;
        end else if (sclk_fall) begin
            tx_shift <= tx_shift << 1;
        end
        if (sclk_rise) begin
            rx_shift <= {rx_shift[W-2:0], miso}; // Sample on rising sclk
        end
        if (state == st_cs_release) begin
            rx_byte <= rx_shift;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (state == st_transfer) |-> !cs_n);

    // No clock edges toward the slave outside a frame
    assert property (@(posedge clk) disable iff (rst)
        cs_n |-> !sclk);

endmodule

//--- spi_trigger_monitor.sv
/* Trigger monitor
   Pattern LFSR stepped once per frame fires a one-cycle abort on a low-byte match */
`timescale 1ns/1ps
`include "spi_host_params.svh"

module spi_trigger_monitor import spi_host_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic frame_end,
    output logic force_abort
);

    logic [23:0] lfsr;
    logic        match;
    logic        match_q; // Match already reported

    assign match = (lfsr[7:0] == `SPI_TRIG_VALUE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lfsr <= `SPI_LFSR_SEED;
        end else if (frame_end) begin
            // Fibonacci feedback from taps 23 18 12 2
            lfsr <= {lfsr[22:0], lfsr[23] ^ lfsr[18] ^ lfsr[12] ^ lfsr[2]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            match_q     <= 1'b0;
            force_abort <= 1'b0;
        end else begin
            match_q     <= match;
            force_abort <= match && !match_q; // Rearms once the value moves on
        end
    end

endmodule

//--- spi_rx_collector.sv
/* Receive collector
   Registers each received byte and counts completed and aborted frames */
`timescale 1ns/1ps

module spi_rx_collector import spi_host_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_strobe,
    input  logic        abort_strobe,
    input  spi_frame_t  rx_byte,
    output logic        rx_valid,
    output spi_frame_t  rx_data,
    output logic [15:0] frame_count,
    output logic [15:0] abort_count
);

    always_ff @(posedge clk) begin
        if (rx_strobe) begin
            rx_data <= rx_byte;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_valid    <= 1'b0;
            frame_count <= '0;
            abort_count <= '0;
        end else begin
            rx_valid <= rx_strobe; // Consumer always accepts
            if (rx_strobe) begin
                frame_count <= frame_count + 1'b1;
            end
            if (abort_strobe) begin
                abort_count <= abort_count + 1'b1;
            end
        end
    end

    // A frame either completes or aborts
    assert property (@(posedge clk) disable iff (rst)
        !(rx_strobe && abort_strobe));

endmodule

//--- spi_host_top.sv
/* SPI host top level
   Credit-fed command queue, shift engine, trigger monitor and receive collector */
`timescale 1ns/1ps

module spi_host_top import spi_host_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        cmd_valid,
    input  spi_frame_t  cmd_data,
    output logic        cmd_credit,
    output logic        spi_sclk,
    output logic        spi_mosi,
    output logic        spi_cs_n,
    input  logic        spi_miso,
    output logic        rx_valid,
    output spi_frame_t  rx_data,
    output logic [15:0] frame_count,
    output logic [15:0] abort_count
);

    logic       force_abort;
    logic       frame_end;
    logic       rx_strobe;
    logic       abort_strobe;
    spi_frame_t rx_byte;

    spi_cmd_if cmd_if_i ();

    spi_cmd_queue spi_cmd_queue_i (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (cmd_valid),
        .in_data   (cmd_data),
        .in_credit (cmd_credit),
        .cmd       (cmd_if_i.queue_mp)
    );

    spi_shift_engine spi_shift_engine_i (
        .clk          (clk),
        .rst          (rst),
        .cmd          (cmd_if_i.engine_mp),
        .force_abort  (force_abort),
        .miso         (spi_miso),
        .sclk         (spi_sclk),
        .mosi         (spi_mosi),
        .cs_n         (spi_cs_n),
        .rx_strobe    (rx_strobe),
        .rx_byte      (rx_byte),
        .abort_strobe (abort_strobe),
        .frame_end    (frame_end)
    );

    spi_trigger_monitor spi_trigger_monitor_i (
        .clk         (clk),
        .rst         (rst),
        .frame_end   (frame_end),
        .force_abort (force_abort)
    );

    spi_rx_collector spi_rx_collector_i (
        .clk          (clk),
        .rst          (rst),
        .rx_strobe    (rx_strobe),
        .abort_strobe (abort_strobe),
        .rx_byte      (rx_byte),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .frame_count  (frame_count),
        .abort_count  (abort_count)
    );

endmodule

//--- tb_spi_host.sv
/* SPI host testbench
   Random credit-limited producer, inverting loopback slave, byte and LFSR reference model */
`timescale 1ns/1ps
`include "spi_host_params.svh"

module tb_spi_host import spi_host_pkg::*; ();

    localparam int W            = `SPI_DATA_WIDTH;
    localparam int DEPTH        = `SPI_QUEUE_DEPTH;
    localparam int NUM_BYTES    = 40;
    localparam int BURST        = 6;    // Back-to-back bytes at the start
    localparam int CREDIT_LIMIT = 500;  // Cycles
    localparam int DRAIN_LIMIT  = 2000;

    logic        clk;
    logic        rst;
    logic        cmd_valid;
    spi_frame_t  cmd_data;
    logic        cmd_credit;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_cs_n;
    logic        spi_miso;
    logic        rx_valid;
    spi_frame_t  rx_data;
    logic [15:0] frame_count;
    logic [15:0] abort_count;

    int          credits;
    int          value_errors;
    int          protocol_errors;
    int          timeouts;
    int          exp_completes;
    int          exp_aborts;
    int          frames_seen;
    int          rises;
    spi_frame_t  exp_q [$];        // Expected received bytes, in order
    logic        abort_slot [NUM_BYTES];
    logic [31:0] rng;
    logic        prev_sclk;
    logic        prev_cs_n;

    spi_host_top spi_host_top_i (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_data    (cmd_data),
        .cmd_credit  (cmd_credit),
        .spi_sclk    (spi_sclk),
        .spi_mosi    (spi_mosi),
        .spi_cs_n    (spi_cs_n),
        .spi_miso    (spi_miso),
        .rx_valid    (rx_valid),
        .rx_data     (rx_data),
        .frame_count (frame_count),
        .abort_count (abort_count)
    );

    assign spi_miso = ~spi_mosi; // Inverting loopback slave

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Fibonacci step with taps 23 18 12 2
    function automatic logic [23:0] lfsr_step(input logic [23:0] s);
        return {s[22:0], s[23] ^ s[18] ^ s[12] ^ s[2]};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR %0t %s: expected %0h, got %0h", $time, name, expected, got);
            value_errors++;
        end
    endtask

    task automatic push_byte(input spi_frame_t value);
        int waited;
        waited = 0;
        while (credits == 0 && waited < CREDIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (credits == 0) begin
            $display("Timeout: no credit came back within %0d cycles", CREDIT_LIMIT);
            timeouts++;
        end else begin
            cmd_valid = 1'b1;
            cmd_data  = value;
            credits--;
            @(posedge clk);
            #1;
            cmd_valid = 1'b0;
        end
    endtask

    // Credit return to the producer
    initial begin
        forever begin
            @(negedge clk);
            if (!rst && cmd_credit) begin
                if (credits >= DEPTH) begin
                    $display("Credit returned at %0t while the producer held all credits", $time);
                    protocol_errors++;
                end else begin
                    credits++;
                end
            end
        end
    end

    // Received bytes against the model queue
    initial begin
        spi_frame_t expected;
        forever begin
            @(negedge clk);
            if (!rst && rx_valid) begin
                if (exp_q.size() == 0) begin
                    $display("Unexpected rx_valid at %0t with no frame outstanding", $time);
                    protocol_errors++;
                end else begin
                    expected = exp_q.pop_front();
                    check_value("rx_data", rx_data, expected);
                end
            end
        end
    end

    // Serial clock only inside a frame and W rising edges per frame
    initial begin
        prev_sclk = 1'b0;
        prev_cs_n = 1'b1;
        rises     = 0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                if (prev_cs_n && spi_cs_n && (spi_sclk != prev_sclk)) begin
                    $display("spi_sclk toggled at %0t while spi_cs_n was high", $time);
                    protocol_errors++;
                end
                if (!spi_cs_n && spi_sclk && !prev_sclk) begin
                    rises++;
                end
                if (!prev_cs_n && spi_cs_n) begin
                    check_value("spi_sclk rising edges", rises, W);
                    frames_seen++;
                    rises = 0;
                end
            end
            prev_sclk = spi_sclk;
            prev_cs_n = spi_cs_n;
        end
    end

    initial begin
        logic [23:0] lfsr;
        logic        prev_match;
        logic        pending;
        logic        match;
        int          gap;
        int          waited;
        spi_frame_t  value;

        rst             = 1'b1;
        cmd_valid       = 1'b0;
        cmd_data        = '0;
        credits         = DEPTH;
        value_errors    = 0;
        protocol_errors = 0;
        timeouts        = 0;
        exp_completes   = 0;
        exp_aborts      = 0;
        frames_seen     = 0;
        rng             = 32'd46753;

        // Every frame, completed or aborted, steps the LFSR once
        lfsr       = `SPI_LFSR_SEED;
        prev_match = (lfsr[7:0] == `SPI_TRIG_VALUE);
        pending    = 1'b0;
        for (int i = 0; i < NUM_BYTES; i++) begin
            abort_slot[i] = pending; // Abort lands on the next queued byte
            lfsr          = lfsr_step(lfsr);
            match         = (lfsr[7:0] == `SPI_TRIG_VALUE);
            pending       = match && !prev_match;
            prev_match    = match;
        end

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        @(negedge clk);
        check_value("spi_cs_n", spi_cs_n, 1);
        check_value("spi_sclk", spi_sclk, 0);
        check_value("spi_mosi", spi_mosi, 0);
        check_value("rx_valid", rx_valid, 0);
        check_value("cmd_credit", cmd_credit, 0);
        check_value("frame_count", frame_count, 0);
        check_value("abort_count", abort_count, 0);
        @(posedge clk);
        #1;

        for (int i = 0; i < NUM_BYTES && timeouts == 0; i++) begin
            rng   = xorshift32(rng);
            value = rng[W-1:0];
            gap   = 0;
            // Trigger slot bytes go out back to back so they are queued at the abort
            if (i >= BURST && !abort_slot[i] && rng[9:8] == 2'b00) begin
                gap = rng[31:16] % 120;
            end
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
            if (abort_slot[i]) begin
                exp_aborts++;
            end else begin
                exp_q.push_back(~value);
                exp_completes++;
            end
            push_byte(value);
        end
        if (exp_aborts == 0) begin
            $display("The model predicts no trigger match in the first %0d frames", NUM_BYTES);
            protocol_errors++;
        end

        waited = 0;
        while (timeouts == 0 && !(exp_q.size() == 0 && credits == DEPTH)) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited >= DRAIN_LIMIT) begin
                $display("Timeout: frames still outstanding after %0d cycles", DRAIN_LIMIT);
                timeouts++;
            end
        end

        if (timeouts == 0) begin
            repeat (10) @(posedge clk); // Let the last abort reach the counter
            @(negedge clk);
            check_value("frame_count", frame_count, exp_completes);
            check_value("abort_count", abort_count, exp_aborts);
            check_value("spi_cs_n frames", frames_seen, exp_completes);
        end

        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeouts);
        if (value_errors + protocol_errors + timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+.
spi_host_pkg.sv
spi_cmd_if.sv
spi_cmd_queue.sv
spi_shift_engine.sv
spi_trigger_monitor.sv
spi_rx_collector.sv
spi_host_top.sv
tb_spi_host.sv

//--- Bender.yml
package:
  name: spi_host

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - spi_host_pkg.sv
      - spi_cmd_if.sv
      - spi_cmd_queue.sv
      - spi_shift_engine.sv
      - spi_trigger_monitor.sv
      - spi_rx_collector.sv
      - spi_host_top.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_spi_host.sv
